//--- flist.f
hw/fpm_pkg.sv
hw/fpm_decode.sv
hw/fpm_exp_adder.sv
hw/fpm_classify.sv
hw/fpm_top.sv
verification/fpm_tb.sv

//--- hw/fpm_classify.sv
// *****************************
// shift saturates at align_limit
// fixed-point ops give an all-zero result
// *****************************

module fpm_classify import fpm_pkg::*; (
	input logic clk_sys,
	input logic _0_f,
	input logic sum_stb,
	input fpm_sum_t sum,
	output logic res_stb,
	output fpm_result_t res
);

	logic signed [sum_w-1:0] sum_s;
	logic [sum_w-1:0] sum_abs;
	logic [exp_w-1:0] exp_n;
	logic [shift_w-1:0] shift_n;
	logic g_n;
	logic wdt_n;
	logic ovf_n;
	logic unf_n;
	logic [exp_w-1:0] exp_q;
	logic [shift_w-1:0] shift_q;
	logic fp_q;
	logic g_q;
	logic wdt_q;
	logic ovf_q;
	logic unf_q;

	assign sum_s = sum.sum;
	assign sum_abs = sum_s[sum_w-1] ? -sum_s : sum_s;

	always_comb begin
		exp_n = '0;
		shift_n = '0;
		g_n = 1'b0;
		wdt_n = 1'b0;
		ovf_n = 1'b0;
		unf_n = 1'b0;
		if (sum.op.af | sum.op.sf) begin
			// alignment: negative difference means A is the smaller one
			g_n = sum.ge40;
			wdt_n = sum_s[sum_w-1];
			exp_n = wdt_n ? sum.exp_b : sum.exp_a;
			shift_n = sum.ge40 ? shift_w'(align_limit) : sum_abs[shift_w-1:0];
		end else if (sum.op.mf | sum.op.df) begin
			// result exponent, range checked on the full sum
			exp_n = sum_s[exp_w-1:0];
			ovf_n = sum_s > exp_max;
			unf_n = sum_s < exp_min;
		end
	end

	// strobe and indicators
	always_ff @(posedge clk_sys or posedge _0_f) begin
		if (_0_f) begin
			res_stb <= 1'b0;
			g_q <= 1'b0;
			wdt_q <= 1'b0;
			ovf_q <= 1'b0;
			unf_q <= 1'b0;
		end else begin
			res_stb <= sum_stb;
			if (sum_stb) begin
				g_q <= g_n;
				wdt_q <= wdt_n;
				ovf_q <= ovf_n;
				unf_q <= unf_n;
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (sum_stb) begin
			exp_q <= exp_n;
			shift_q <= shift_n;
			fp_q <= sum.op.ff;
		end
	end

	assign res = '{exp: exp_q, shift: shift_q, g: g_q, wdt: wdt_q,
		ovf: ovf_q, unf: unf_q, fp: fp_q};

	// overflow and underflow exclude each other on any reported result
	a_ovf_unf: assert property (@(posedge clk_sys) disable iff (_0_f)
		res_stb |-> !(res.ovf && res.unf));

endmodule

//--- hw/fpm_decode.sv
// *****************************
// op_ena is sampled only with op_stb
// a disabled strobe is dropped here
// *****************************

module fpm_decode import fpm_pkg::*; (
	input logic clk_sys,
	input logic _0_f,
	input logic op_stb,
	input logic [2:0] op_code,
	input logic op_ena,
	input logic signed [exp_w-1:0] exp_a,
	input logic signed [exp_w-1:0] exp_b,
	output logic dec_stb,
	output fpm_dec_t dec
);

	fpm_op_t op_n;
	fpm_bsel_e bsel_n;
	logic carry_n;

	// 3-to-8 decode, codes 4..7 are floating point
	always_comb begin
		op_n = '0;
		case (op_code)
			3'd0: op_n.ad = 1'b1;
			3'd1: op_n.sd = 1'b1;
			3'd2: op_n.mw = 1'b1;
			3'd3: op_n.dw = 1'b1;
			3'd4: op_n.af = 1'b1;
			3'd5: op_n.sf = 1'b1;
			3'd6: op_n.mf = 1'b1;
			default: op_n.df = 1'b1;
		endcase
		op_n.ff = op_code[2];
		op_n.ss = ~op_code[2];
	end

	// adder setup: difference for af/sf/df, sum for mf
	always_comb begin
		bsel_n = b_zero;
		carry_n = 1'b0;
		if (op_n.af | op_n.sf | op_n.df) begin
			bsel_n = b_inv;
			carry_n = 1'b1;
		end else if (op_n.mf) begin
			bsel_n = b_pass;
		end
	end

	always_ff @(posedge clk_sys or posedge _0_f) begin
		if (_0_f) begin
			dec_stb <= 1'b0;
		end else begin
			dec_stb <= op_stb & op_ena;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (op_stb & op_ena) begin
			dec.op <= op_n;
			dec.bsel <= bsel_n;
			dec.carry_in <= carry_n;
			dec.exp_a <= exp_a;
			dec.exp_b <= exp_b;
		end
	end

	a_op_onehot: assert property (@(posedge clk_sys) disable iff (_0_f)
		dec_stb |-> $onehot({dec.op.ad, dec.op.sd, dec.op.mw, dec.op.dw,
			dec.op.af, dec.op.sf, dec.op.mf, dec.op.df}));

endmodule

//--- hw/fpm_exp_adder.sv
// *****************************
// both operands are sign extended to sum_w
// so the sum or difference never wraps
// *****************************

module fpm_exp_adder import fpm_pkg::*; (
	input logic clk_sys,
	input logic _0_f,
	input logic dec_stb,
	input fpm_dec_t dec,
	output logic sum_stb,
	output fpm_sum_t sum
);

	logic [exp_w-1:0] b_bus;
	logic signed [sum_w-1:0] a_ext;
	logic signed [sum_w-1:0] b_ext;
	logic signed [sum_w-1:0] carry_ext;
	logic signed [sum_w-1:0] sum_n;
	logic ge40_n;

	// B-bus function
	always_comb begin
		case (dec.bsel)
			b_inv: b_bus = ~dec.exp_b;
			b_pass: b_bus = dec.exp_b;
			b_zero: b_bus = '0;
			default: b_bus = '0;
		endcase
	end

	// extension bit and carry sign come from the operand sign
	assign a_ext = {{(sum_w - exp_w){dec.exp_a[exp_w-1]}}, dec.exp_a};
	assign b_ext = {{(sum_w - exp_w){b_bus[exp_w-1]}}, b_bus};
	assign carry_ext = {{(sum_w - 1){1'b0}}, dec.carry_in};

	// inverted B plus carry in gives a - b
	assign sum_n = a_ext + b_ext + carry_ext;

	// |sum| >= 40
	assign ge40_n = (sum_n >= align_limit) || (sum_n <= -align_limit);

	always_ff @(posedge clk_sys or posedge _0_f) begin
		if (_0_f) begin
			sum_stb <= 1'b0;
		end else begin
			sum_stb <= dec_stb;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (dec_stb) begin
			sum.op <= dec.op;
			sum.exp_a <= dec.exp_a;
			sum.exp_b <= dec.exp_b;
			sum.sum <= sum_n;
			sum.ge40 <= ge40_n;
		end
	end

	// incoming setup is a defined B-bus function, carry only with inverted B
	a_carry_inv: assert property (@(posedge clk_sys) disable iff (_0_f)
		dec_stb |-> (dec.bsel inside {b_inv, b_pass, b_zero}) &&
			(dec.carry_in == (dec.bsel == b_inv)));

endmodule

//--- hw/fpm_pkg.sv
// *****************************
// exponents are 8-bit two's complement
// adder result is 10 bits wide and never wraps
// *****************************

package fpm_pkg;

	// exponent datapath
	localparam int exp_w = 8;
	localparam int sum_w = 10;
	localparam int shift_w = 6;

	// differences at or beyond this drop the smaller operand
	localparam int align_limit = 40;

	// representable result exponent range
	localparam int exp_max = (1 << (exp_w - 1)) - 1;
	localparam int exp_min = -(1 << (exp_w - 1));

	// decoded operation, one-hot plus float/fixed levels
	typedef struct packed {
		logic ad;
		logic sd;
		logic mw;
		logic dw;
		logic af;
		logic sf;
		logic mf;
		logic df;
		logic ff;
		logic ss;
	} fpm_op_t;

	// B-bus function
	typedef enum logic [1:0] {
		b_inv = 2'd0,
		b_pass = 2'd1,
		b_zero = 2'd2
	} fpm_bsel_e;

	// stage 1 output
	typedef struct packed {
		fpm_op_t op;
		fpm_bsel_e bsel;
		logic carry_in;
		logic signed [exp_w-1:0] exp_a;
		logic signed [exp_w-1:0] exp_b;
	} fpm_dec_t;

	// stage 2 output
	typedef struct packed {
		fpm_op_t op;
		logic signed [exp_w-1:0] exp_a;
		logic signed [exp_w-1:0] exp_b;
		logic signed [sum_w-1:0] sum;
		logic ge40;
	} fpm_sum_t;

	// pipeline result
	typedef struct packed {
		logic [exp_w-1:0] exp;
		logic [shift_w-1:0] shift;
		logic g;
		logic wdt;
		logic ovf;
		logic unf;
		logic fp;
	} fpm_result_t;

endpackage

//--- hw/fpm_top.sv
// *****************************
// result 3 cycles after an enabled op_stb
// no back-pressure, one op per cycle max
// *****************************

module fpm_top import fpm_pkg::*; (
	input logic clk_sys,
	input logic _0_f,
	input logic op_stb,
	input logic [2:0] op_code,
	input logic op_ena,
	input logic signed [exp_w-1:0] exp_a,
	input logic signed [exp_w-1:0] exp_b,
	output logic res_stb,
	output fpm_result_t res
);

	logic dec_stb;
	fpm_dec_t dec;
	logic sum_stb;
	fpm_sum_t sum;

	// stage 1: instruction decode
	fpm_decode fpm_decode_inst (
		.clk_sys(clk_sys),
		._0_f(_0_f),
		.op_stb(op_stb),
		.op_code(op_code),
		.op_ena(op_ena),
		.exp_a(exp_a),
		.exp_b(exp_b),
		.dec_stb(dec_stb),
		.dec(dec)
	);

	// stage 2: exponent adder
	fpm_exp_adder fpm_exp_adder_inst (
		.clk_sys(clk_sys),
		._0_f(_0_f),
		.dec_stb(dec_stb),
		.dec(dec),
		.sum_stb(sum_stb),
		.sum(sum)
	);

	// stage 3: indicators and result exponent
	fpm_classify fpm_classify_inst (
		.clk_sys(clk_sys),
		._0_f(_0_f),
		.sum_stb(sum_stb),
		.sum(sum),
		.res_stb(res_stb),
		.res(res)
	);

endmodule

//--- run_sim.sh
#!/bin/sh
# builds and runs the fpm testbench with Verilator
# exits non-zero when the build fails or the log reports errors

cd "$(dirname "$0")" || exit 1

obj_dir=obj_dir
log_file=sim.log
fail_text="Done: errors found"

verilator --binary --timing --assert -Wno-fatal \
	--top-module fpm_tb -Mdir "$obj_dir" -f flist.f
if [ $? -ne 0 ]; then
	echo "run_sim: verilator build failed"
	exit 1
fi

"./$obj_dir/Vfpm_tb" > "$log_file" 2>&1
run_status=$?
cat "$log_file"

grep -q "$fail_text" "$log_file"
if [ $? -eq 0 ]; then
	echo "run_sim: simulation failed"
	exit 1
fi

if [ $run_status -ne 0 ]; then
	echo "run_sim: simulation exited with status $run_status"
	exit 1
fi

grep -q "Done: no errors" "$log_file"
if [ $? -ne 0 ]; then
	echo "run_sim: simulation ended without a result line"
	exit 1
fi

echo "run_sim: simulation passed"
exit 0

//--- verification/fpm_stim.txt
# ena code exp_a exp_b | exp shift g wdt ovf unf fp (all decimal)
# exp is the expected 8-bit result exponent read as signed; ena 0 lines give no result
1 4 10 5 10 5 0 0 0 0 1
1 4 5 10 10 5 0 1 0 0 1
1 4 0 0 0 0 0 0 0 0 1
1 4 39 0 39 39 0 0 0 0 1
1 4 40 0 40 40 1 0 0 0 1
1 4 0 40 40 40 1 1 0 0 1
1 4 0 41 41 40 1 1 0 0 1
1 4 0 39 39 39 0 1 0 0 1
0 4 0 40 0 0 0 0 0 0 0
1 5 -20 19 19 39 0 1 0 0 1
1 5 20 -20 20 40 1 0 0 0 1
1 5 -20 20 20 40 1 1 0 0 1
1 5 -21 20 20 40 1 1 0 0 1
1 5 19 -20 19 39 0 0 0 0 1
1 4 127 -128 127 40 1 0 0 0 1
1 4 -128 127 127 40 1 1 0 0 1
1 5 -128 -128 -128 0 0 0 0 0 1
0 5 1 2 0 0 0 0 0 0 0
1 4 100 90 100 10 0 0 0 0 1
1 4 -50 -60 -50 10 0 0 0 0 1
1 4 -60 -50 -50 10 0 1 0 0 1
1 5 1 2 2 1 0 1 0 0 1
1 5 2 1 2 1 0 0 0 0 1
1 4 -1 -40 -1 39 0 0 0 0 1
1 4 -1 -41 -1 40 1 0 0 0 1
1 5 -41 -1 -1 40 1 1 0 0 1
1 5 -42 -1 -1 40 1 1 0 0 1
1 4 63 0 63 40 1 0 0 0 1
1 4 0 63 63 40 1 1 0 0 1
1 5 38 0 38 38 0 0 0 0 1
1 4 -100 -127 -100 27 0 0 0 0 1
1 5 -127 -100 -100 27 0 1 0 0 1
0 6 100 28 0 0 0 0 0 0 0
1 6 3 4 7 0 0 0 0 0 1
1 6 -3 -4 -7 0 0 0 0 0 1
1 6 100 27 127 0 0 0 0 0 1
1 6 100 28 -128 0 0 0 1 0 1
1 6 -100 -28 -128 0 0 0 0 0 1
1 6 -100 -29 127 0 0 0 0 1 1
1 6 127 127 -2 0 0 0 1 0 1
1 6 -128 -128 0 0 0 0 0 1 1
1 6 64 64 -128 0 0 0 1 0 1
0 7 0 -128 0 0 0 0 0 0 0
1 6 -64 -65 127 0 0 0 0 1 1
1 6 -64 -64 -128 0 0 0 0 0 1
1 6 63 64 127 0 0 0 0 0 1
1 6 0 0 0 0 0 0 0 0 1
1 6 127 -128 -1 0 0 0 0 0 1
1 6 90 60 -106 0 0 0 1 0 1
1 6 -90 -60 106 0 0 0 0 1 1
1 6 -5 10 5 0 0 0 0 0 1
1 7 20 5 15 0 0 0 0 0 1
1 7 5 20 -15 0 0 0 0 0 1
1 7 100 -27 127 0 0 0 0 0 1
1 7 100 -28 -128 0 0 0 1 0 1
1 7 -100 28 -128 0 0 0 0 0 1
1 7 -100 29 127 0 0 0 0 1 1
0 0 10 5 0 0 0 0 0 0 0
1 7 127 -128 -1 0 0 0 1 0 1
1 7 -128 127 1 0 0 0 0 1 1
1 7 0 -128 -128 0 0 0 1 0 1
1 7 -1 127 -128 0 0 0 0 0 1
1 7 -2 127 127 0 0 0 0 1 1
1 7 0 -127 127 0 0 0 0 0 1
1 7 50 50 0 0 0 0 0 0 1
1 7 -64 64 -128 0 0 0 0 0 1
1 7 64 -64 -128 0 0 0 1 0 1
1 0 10 5 0 0 0 0 0 0 0
1 1 -40 40 0 0 0 0 0 0 0
1 2 127 127 0 0 0 0 0 0 0
1 3 -128 -128 0 0 0 0 0 0 0
0 3 64 64 0 0 0 0 0 0 0
1 0 100 -100 0 0 0 0 0 0 0
1 1 0 41 0 0 0 0 0 0 0
1 2 -128 127 0 0 0 0 0 0 0
1 3 64 64 0 0 0 0 0 0 0
1 0 -1 -1 0 0 0 0 0 0 0
1 1 127 -128 0 0 0 0 0 0 0
1 2 40 0 0 0 0 0 0 0 0
1 3 0 -40 0 0 0 0 0 0 0
0 4 127 -128 0 0 0 0 0 0 0
1 4 12 -30 12 40 1 0 0 0 1
1 6 70 57 127 0 0 0 0 0 1
1 7 -70 59 127 0 0 0 0 1 1
1 0 5 5 0 0 0 0 0 0 0
1 5 -30 12 12 40 1 1 0 0 1
1 6 -70 -59 127 0 0 0 0 1 1
1 7 70 -58 -128 0 0 0 1 0 1
1 4 33 33 33 0 0 0 0 0 1
1 5 -7 -46 -7 39 0 0 0 0 1
0 6 -100 -29 0 0 0 0 0 0 0
1 2 1 1 0 0 0 0 0 0 0

//--- verification/fpm_tb.sv
// *****************************
// vectors come from verification/fpm_stim.txt
// run from the project root
// *****************************

module fpm_tb import fpm_pkg::*; ();

	localparam string stim_path = "verification/fpm_stim.txt";
	localparam int latency = 3;
	localparam int drain_limit = 64;

	// expected result and the cycle its op_stb was driven
	typedef struct packed {
		fpm_result_t res;
		logic [31:0] issue;
	} pending_t;

	logic clk_sys;
	logic _0_f;
	logic op_stb;
	logic [2:0] op_code;
	logic op_ena;
	logic signed [exp_w-1:0] exp_a;
	logic signed [exp_w-1:0] exp_b;
	logic res_stb;
	fpm_result_t res;

	pending_t pending[$];
	int unsigned cyc = 0;
	int unsigned n_checked = 0;

	fpm_top fpm_top_inst (
		.clk_sys(clk_sys),
		._0_f(_0_f),
		.op_stb(op_stb),
		.op_code(op_code),
		.op_ena(op_ena),
		.exp_a(exp_a),
		.exp_b(exp_b),
		.res_stb(res_stb),
		.res(res)
	);

	initial begin
		clk_sys = 1'b0;
		forever #4 clk_sys = ~clk_sys;
	end

	always @(posedge clk_sys) begin
		cyc <= cyc + 1;
	end

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("Done: errors found");
		$fatal(1, "simulation stopped");
	endtask

	task automatic compare_field(input string name, input int got, input int want);
		assert (got == want)
		else fail_run($sformatf("mismatch at %0t: %s got %0d expected %0d",
			$time, name, got, want));
	endtask

	// outputs are sampled mid-cycle
	always @(negedge clk_sys) begin
		pending_t head;
		if (_0_f) begin
			assert (!res_stb && !res.g && !res.wdt && !res.ovf && !res.unf)
			else fail_run("result strobe or an indicator is high during reset");
		end else if (res_stb) begin
			assert (pending.size() > 0)
			else fail_run("result strobe arrived with no operation pending");
			head = pending.pop_front();
			compare_field("latency", int'(cyc - head.issue), latency);
			compare_field("res.exp", res.exp, head.res.exp);
			compare_field("res.shift", res.shift, head.res.shift);
			compare_field("res.g", res.g, head.res.g);
			compare_field("res.wdt", res.wdt, head.res.wdt);
			compare_field("res.ovf", res.ovf, head.res.ovf);
			compare_field("res.unf", res.unf, head.res.unf);
			compare_field("res.fp", res.fp, head.res.fp);
			n_checked++;
		end
	end

	initial begin
		int fd;
		int n;
		int ena;
		int code;
		int a;
		int b;
		int e_exp;
		int e_shift;
		int e_g;
		int e_wdt;
		int e_ovf;
		int e_unf;
		int e_fp;
		int gap;
		int idx;
		int wait_cnt;
		int unsigned seed;
		string line;
		pending_t item;

		op_stb = 1'b0;
		op_code = '0;
		op_ena = 1'b0;
		exp_a = '0;
		exp_b = '0;
		_0_f = 1'b1;
		seed = $urandom(32'h5660);

		repeat (16) @(posedge clk_sys);
		@(negedge clk_sys);
		_0_f = 1'b0;
		// a few idle cycles, the checker flags any stray strobe
		repeat (4) @(negedge clk_sys);

		fd = $fopen(stim_path, "r");
		if (fd == 0) begin
			fail_run("cannot open the stimulus file");
		end
		idx = 0;
		while (!$feof(fd)) begin
			line = "";
			n = $fgets(line, fd);
			if (n > 0 && line.len() > 1 && line.getc(0) != "#") begin
				n = $sscanf(line, "%d %d %d %d %d %d %d %d %d %d %d", ena, code, a, b,
					e_exp, e_shift, e_g, e_wdt, e_ovf, e_unf, e_fp);
				if (n != 11) begin
					fail_run($sformatf("malformed stimulus line %0d", idx));
				end
				op_stb = 1'b1;
				op_code = code[2:0];
				op_ena = ena[0];
				exp_a = a[exp_w-1:0];
				exp_b = b[exp_w-1:0];
				// disabled ops must never come out
				if (ena != 0) begin
					item.res.exp = e_exp[exp_w-1:0];
					item.res.shift = e_shift[shift_w-1:0];
					item.res.g = e_g[0];
					item.res.wdt = e_wdt[0];
					item.res.ovf = e_ovf[0];
					item.res.unf = e_unf[0];
					item.res.fp = e_fp[0];
					item.issue = cyc;
					pending.push_back(item);
				end
				@(negedge clk_sys);
				op_stb = 1'b0;
				op_ena = 1'b0;
				// bursts of back-to-back ops, random gaps elsewhere
				gap = (idx % 16 < 6) ? 0 : int'($urandom % 4);
				repeat (gap) @(negedge clk_sys);
				idx++;
			end
		end
		$fclose(fd);

		wait_cnt = 0;
		while (pending.size() != 0 && wait_cnt < drain_limit) begin
			@(negedge clk_sys);
			wait_cnt++;
		end
		// extra cycles to catch late or extra strobes
		repeat (8) @(negedge clk_sys);

		if (pending.size() != 0) begin
			fail_run($sformatf("%0d results never arrived", pending.size()));
		end else begin
			$display("checked %0d results from %0d vectors", n_checked, idx);
			$display("Done: no errors");
			$finish;
		end
	end

endmodule
